/* verilog/cpuPkg.sv */
`default_nettype none

package cpuPkg;

  //////////////////////////////////////////////////////////////////////
  // Widths that carry a meaning
  //////////////////////////////////////////////////////////////////////
  typedef logic [15:0] dataWord;     // Register and ALU data
  typedef logic [15:0] pcWord;       // Instruction address
  typedef logic [15:0] instrWord;    // One instruction
  typedef logic [3:0]  regAddr;      // R0..R15
  typedef logic [3:0]  shiftAmount;  // Shift count from [3:0]
  typedef logic [2:0]  branchCond;   // ccc field of B

  // Opcode field [15:12]
  typedef enum logic [3:0] {
    opAdd   = 4'd0,
    opSub   = 4'd1,
    opAnd   = 4'd2,
    opNor   = 4'd3,
    opSll   = 4'd4,
    opSrl   = 4'd5,
    opSra   = 4'd6,
    opLlb   = 4'd7,   // Sign-extended imm8
    opLhb   = 4'd8,   // imm8 into high byte
    opNop9  = 4'd9,   // Former load/store slots
    opNop10 = 4'd10,
    opNop11 = 4'd11,
    opB     = 4'd12,  // Conditional branch
    opNop13 = 4'd13,  // Former jump slots
    opNop14 = 4'd14,
    opHlt   = 4'd15
  } opCode;

  //////////////////////////////////////////////////////////////////////
  // Pipeline and bus structs
  //////////////////////////////////////////////////////////////////////
  typedef struct packed {
    logic z;  // Zero
    logic n;  // Negative
    logic v;  // Signed overflow
  } aluFlags;

  // Program load port, testbench side
  typedef struct packed {
    logic     en;
    pcWord    addr;
    instrWord data;
  } progWrite;

  typedef struct packed {
    logic     valid;
    pcWord    pc;     // Address the instr came from
    instrWord instr;
  } ifIdReg;

  typedef struct packed {
    logic      valid;
    opCode     op;
    regAddr    rd;         // Destination
    regAddr    rs;         // Port A address, rd for LHB
    regAddr    rt;         // Port B address, also shamt
    dataWord   rsData;
    dataWord   rtData;
    dataWord   imm;        // Already extended
    branchCond cond;
    pcWord     pc;
    logic      writesReg;  // Opcodes 0..8
    logic      isBranch;
    logic      isHalt;
  } idExReg;

  // Result leaving EX, also the register file write port
  typedef struct packed {
    logic    valid;
    regAddr  addr;
    dataWord data;
  } wbBus;

  //////////////////////////////////////////////////////////////////////
  // Constants
  //////////////////////////////////////////////////////////////////////
  localparam int       imemDepth    = 256;
  localparam int       imemAddrBits = $clog2(imemDepth);
  localparam regAddr   linkRegZero  = 4'd0;     // Hardwired zero register
  localparam instrWord nopInstr     = 16'h9000; // Opcode 9, does nothing

endpackage

`default_nettype wire

/* verilog/fetchUnit.sv */
`default_nettype none

module fetchUnit (
  input  logic              clk,
  input  logic              reset,
  input  cpuPkg::progWrite  progWrite,   // Loader port, live only in reset
  input  logic              redirect,    // Taken branch in EX
  input  cpuPkg::pcWord     redirectPc,
  input  logic              haltSeen,    // HLT sitting in ID
  output cpuPkg::pcWord     pc,
  output cpuPkg::ifIdReg    ifId
);

  cpuPkg::instrWord imem [cpuPkg::imemDepth];
  cpuPkg::instrWord fetched;
  logic             frozen;  // Set once HLT survives ID

  //////////////////////////////////////////////////////////////////////
  // Instruction memory
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset && progWrite.en) begin
      imem[progWrite.addr[cpuPkg::imemAddrBits-1:0]] <= progWrite.data;
    end
  end

  assign fetched = imem[pc[cpuPkg::imemAddrBits-1:0]];  // Async read

  //////////////////////////////////////////////////////////////////////
  // PC and IF/ID register
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      pc         <= '0;
      frozen     <= 1'b0;
      ifId.valid <= 1'b0;
      ifId.pc    <= '0;
      ifId.instr <= cpuPkg::nopInstr;
    end else if (redirect) begin
      // Branch wins over a halt in ID
      pc         <= redirectPc;
      ifId.valid <= 1'b0;              // Flush shadow slot
      ifId.pc    <= redirectPc;
      ifId.instr <= cpuPkg::nopInstr;
    end else if (haltSeen || frozen) begin
      frozen     <= 1'b1;              // PC holds from here on
      ifId.valid <= 1'b0;
      ifId.pc    <= pc;
      ifId.instr <= cpuPkg::nopInstr;
    end else begin
      pc         <= pc + 16'd1;
      ifId.valid <= 1'b1;
      ifId.pc    <= pc;
      ifId.instr <= fetched;
    end
  end

endmodule

`default_nettype wire

/* verilog/regFile.sv */
`default_nettype none

module regFile (
  input  logic            clk,
  input  logic            reset,
  input  cpuPkg::regAddr  rdAddrA,
  input  cpuPkg::regAddr  rdAddrB,
  output cpuPkg::dataWord rdDataA,
  output cpuPkg::dataWord rdDataB,
  input  cpuPkg::wbBus    wb       // Write port from EX
);

  cpuPkg::dataWord regs [16];

  // Zero register, then bypass, then array
  function automatic cpuPkg::dataWord readPort(input cpuPkg::regAddr addr);
    if (addr == cpuPkg::linkRegZero) return '0;
    if (wb.valid && wb.addr == addr) return wb.data;  // Same-cycle write
    return regs[addr];
  endfunction

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 16; i++) begin
        regs[i] <= '0;
      end
    end else if (wb.valid && wb.addr != cpuPkg::linkRegZero) begin
      regs[wb.addr] <= wb.data;
    end
  end

  always_comb begin
    rdDataA = readPort(rdAddrA);
    rdDataB = readPort(rdAddrB);
  end

endmodule

`default_nettype wire

/* verilog/decodeStage.sv */
`default_nettype none

module decodeStage (
  input  logic            clk,
  input  logic            reset,
  input  cpuPkg::ifIdReg  ifId,
  input  logic            flush,     // Redirect from EX
  output cpuPkg::regAddr  rdAddrA,
  output cpuPkg::regAddr  rdAddrB,
  input  cpuPkg::dataWord rdDataA,
  input  cpuPkg::dataWord rdDataB,
  output logic            haltSeen,
  output cpuPkg::idExReg  idEx
);

  cpuPkg::opCode  op;
  cpuPkg::idExReg idNext;

  //////////////////////////////////////////////////////////////////////
  // Field split and register reads
  //////////////////////////////////////////////////////////////////////
  assign op = cpuPkg::opCode'(ifId.instr[15:12]);

  // LHB merges into its own rd, so rd goes out on port A
  assign rdAddrA = (op == cpuPkg::opLhb) ? ifId.instr[11:8] : ifId.instr[7:4];
  assign rdAddrB = ifId.instr[3:0];

  // Fetch freezes on this, redirect still overrides it
  assign haltSeen = ifId.valid && (op == cpuPkg::opHlt);

  //////////////////////////////////////////////////////////////////////
  // Control and immediates
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    idNext = '0;
    idNext.valid  = ifId.valid && !flush;  // Bubble on flush
    idNext.op     = op;
    idNext.rd     = ifId.instr[11:8];
    idNext.rs     = rdAddrA;               // Matches what was read
    idNext.rt     = rdAddrB;
    idNext.rsData = rdDataA;
    idNext.rtData = rdDataB;
    idNext.cond   = ifId.instr[11:9];
    idNext.pc     = ifId.pc;

    idNext.writesReg = (op <= cpuPkg::opLhb);   // Opcodes 0..8
    idNext.isBranch  = (op == cpuPkg::opB);
    idNext.isHalt    = (op == cpuPkg::opHlt);

    case (op)
      cpuPkg::opLlb: begin
        idNext.imm = {{8{ifId.instr[7]}}, ifId.instr[7:0]};  // Sign-extend
      end
      cpuPkg::opLhb: begin
        idNext.imm = {ifId.instr[7:0], 8'h00};              // Pre-shifted
      end
      cpuPkg::opB: begin
        idNext.imm = {{7{ifId.instr[8]}}, ifId.instr[8:0]}; // 9-bit offset
      end
      default: begin
        idNext.imm = '0;
      end
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // ID/EX register
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      idEx <= '0;
    end else begin
      idEx <= idNext;
    end
  end

endmodule

`default_nettype wire

/* verilog/aluUnit.sv */
`default_nettype none

module aluUnit (
  input  cpuPkg::opCode      op,
  input  cpuPkg::dataWord    a,       // rs, or rd for LHB
  input  cpuPkg::dataWord    b,       // rt
  input  cpuPkg::shiftAmount shamt,
  input  cpuPkg::dataWord    imm,
  output cpuPkg::dataWord    result,
  output cpuPkg::aluFlags    flags,
  output logic               setZ,    // Z write enable
  output logic               setNv    // N and V write enable
);

  cpuPkg::dataWord sum;
  cpuPkg::dataWord diff;
  logic            addOv;
  logic            subOv;

  assign sum  = a + b;  // Wraps
  assign diff = a - b;

  // Signed overflow of the wrapped result
  assign addOv = (a[15] == b[15]) && (sum[15] != a[15]);
  assign subOv = (a[15] != b[15]) && (diff[15] != a[15]);

  always_comb begin
    case (op)
      cpuPkg::opAdd: result = sum;
      cpuPkg::opSub: result = diff;
      cpuPkg::opAnd: result = a & b;
      cpuPkg::opNor: result = ~(a | b);
      cpuPkg::opSll: result = a << shamt;
      cpuPkg::opSrl: result = a >> shamt;
      cpuPkg::opSra: result = $signed(a) >>> shamt;  // Keeps sign
      cpuPkg::opLlb: result = imm;
      cpuPkg::opLhb: result = {imm[15:8], a[7:0]};   // Own low byte stays
      default:       result = '0;
    endcase
  end

  always_comb begin
    flags.z = (result == '0);
    flags.n = result[15];
    case (op)
      cpuPkg::opAdd: flags.v = addOv;
      cpuPkg::opSub: flags.v = subOv;
      default:       flags.v = 1'b0;
    endcase
  end

  // Every ALU-type opcode touches Z, only add and sub touch N and V
  assign setZ  = (op <= cpuPkg::opLhb);
  assign setNv = (op == cpuPkg::opAdd) || (op == cpuPkg::opSub);

endmodule

`default_nettype wire

/* verilog/executeStage.sv */
`default_nettype none

module executeStage (
  input  logic           clk,
  input  logic           reset,
  input  cpuPkg::idExReg idEx,
  output logic           redirect,    // One-cycle strobe
  output cpuPkg::pcWord  redirectPc,
  output cpuPkg::wbBus   wb,
  output logic           hlt
);

  cpuPkg::dataWord opA;
  cpuPkg::dataWord opB;
  cpuPkg::dataWord aluResult;
  cpuPkg::aluFlags aluFl;
  cpuPkg::aluFlags flagReg;    // Z N V from older instructions
  logic            setZ;
  logic            setNv;
  logic            condMet;

  //////////////////////////////////////////////////////////////////////
  // Forwarding from the write-back register
  //////////////////////////////////////////////////////////////////////
  // wb.valid is never set for R0, so no zero check needed here
  assign opA = (wb.valid && wb.addr == idEx.rs) ? wb.data : idEx.rsData;
  assign opB = (wb.valid && wb.addr == idEx.rt) ? wb.data : idEx.rtData;

  aluUnit alu_i (
    .op     (idEx.op),
    .a      (opA),
    .b      (opB),
    .shamt  (idEx.rt),     // Same field as rt
    .imm    (idEx.imm),
    .result (aluResult),
    .flags  (aluFl),
    .setZ   (setZ),
    .setNv  (setNv)
  );

  always_ff @(posedge clk) begin
    if (reset) begin
      flagReg <= '0;
    end else if (idEx.valid) begin
      if (setZ)  flagReg.z <= aluFl.z;
      if (setNv) begin
        flagReg.n <= aluFl.n;
        flagReg.v <= aluFl.v;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Branch resolution
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    case (idEx.cond)
      3'b000:  condMet = !flagReg.z;
      3'b001:  condMet = flagReg.z;
      3'b010:  condMet = !flagReg.z && !flagReg.n;              // Greater than
      3'b011:  condMet = flagReg.n;                             // Less than
      3'b100:  condMet = flagReg.z || (!flagReg.z && !flagReg.n);
      3'b101:  condMet = flagReg.n || flagReg.z;
      3'b110:  condMet = flagReg.v;
      default: condMet = 1'b1;                                  // Always
    endcase
  end

  assign redirect   = idEx.valid && idEx.isBranch && condMet;
  assign redirectPc = idEx.pc + 16'd1 + idEx.imm;  // Relative to next addr

  //////////////////////////////////////////////////////////////////////
  // Write-back register and halt
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      wb  <= '0;
      hlt <= 1'b0;
    end else begin
      wb.valid <= idEx.valid && idEx.writesReg && (idEx.rd != cpuPkg::linkRegZero);
      wb.addr  <= idEx.rd;
      wb.data  <= aluResult;
      if (idEx.valid && idEx.isHalt) hlt <= 1'b1;  // Sticky until reset
    end
  end

endmodule

`default_nettype wire

/* verilog/cpuTop.sv */
`default_nettype none

module cpuTop (
  input  logic             clk,
  input  logic             reset,
  input  cpuPkg::progWrite progWrite,  // Program load during reset
  output cpuPkg::pcWord    pc,
  output logic             hlt,
  output cpuPkg::wbBus     wbBus       // Also feeds the register file
);

  cpuPkg::ifIdReg  ifId;
  cpuPkg::idExReg  idEx;
  cpuPkg::regAddr  rdAddrA;
  cpuPkg::regAddr  rdAddrB;
  cpuPkg::dataWord rdDataA;
  cpuPkg::dataWord rdDataB;
  cpuPkg::pcWord   redirectPc;
  logic            redirect;
  logic            haltSeen;

  //////////////////////////////////////////////////////////////////////
  // Stages
  //////////////////////////////////////////////////////////////////////
  fetchUnit fetch_i (
    .clk        (clk),
    .reset      (reset),
    .progWrite  (progWrite),
    .redirect   (redirect),
    .redirectPc (redirectPc),
    .haltSeen   (haltSeen),
    .pc         (pc),
    .ifId       (ifId)
  );

  regFile regs_i (
    .clk     (clk),
    .reset   (reset),
    .rdAddrA (rdAddrA),
    .rdAddrB (rdAddrB),
    .rdDataA (rdDataA),
    .rdDataB (rdDataB),
    .wb      (wbBus)
  );

  decodeStage decode_i (
    .clk      (clk),
    .reset    (reset),
    .ifId     (ifId),
    .flush    (redirect),   // Kills the ID slot on a taken branch
    .rdAddrA  (rdAddrA),
    .rdAddrB  (rdAddrB),
    .rdDataA  (rdDataA),
    .rdDataB  (rdDataB),
    .haltSeen (haltSeen),
    .idEx     (idEx)
  );

  executeStage execute_i (
    .clk        (clk),
    .reset      (reset),
    .idEx       (idEx),
    .redirect   (redirect),
    .redirectPc (redirectPc),
    .wb         (wbBus),
    .hlt        (hlt)
  );

endmodule

`default_nettype wire

/* bench/cpu_assertions.sv */
`default_nettype none

module cpuAssertions (
  input logic          clk,
  input logic          reset,
  input cpuPkg::pcWord pc,
  input logic          hlt,
  input cpuPkg::wbBus  wbBus
);

  // Halt only clears through reset
  hltSticky: assert property (@(posedge clk) disable iff (reset) hlt |=> hlt)
    else $error("hlt fell without a reset");

  // Fetch frozen once halted
  pcFrozen: assert property (@(posedge clk) disable iff (reset) hlt |=> $stable(pc))
    else $error("pc moved while hlt was high");

  quietInReset: assert property (@(posedge clk) reset |=> !wbBus.valid)
    else $error("wbBus valid while reset was high");  // No register writes in reset

endmodule

bind cpuTop cpuAssertions cpuAssertions_i (
  .clk   (clk),
  .reset (reset),
  .pc    (pc),
  .hlt   (hlt),
  .wbBus (wbBus)
);

`default_nettype wire

/* bench/cpuPrograms.svh */
`ifndef CPU_PROGRAMS_SVH
`define CPU_PROGRAMS_SVH

// One row per program
//   progWords  instructions, rows packed back to back from wordStart
//   expBeats   expected wbBus beats {addr, data} in order, from beatStart
//   haltPc     frozen pc, one past the HLT that stops the row

localparam int progCount = 3;
localparam int wordStart [progCount] = '{0, 19, 70};
localparam int wordCount [progCount] = '{19, 51, 9};
localparam int beatStart [progCount] = '{0, 12, 38};
localparam int beatCount [progCount] = '{12, 26, 6};
localparam logic [15:0] haltPc [progCount] = '{16'd19, 16'd51, 16'd8};

localparam logic [15:0] progWords [79] = '{
  16'h7105, 16'h72FE, 16'h0312, 16'h1431, 16'h2543, 16'h3654,  // LLB, ADD SUB AND NOR chain
  16'h8680, 16'h6764, 16'h5864, 16'h4961,                      // LHB then shifts
  16'h0011, 16'h0A01,                                          // Write R0, read R0
  16'h9123, 16'hA123, 16'hB123, 16'hD123, 16'hE123,            // Dead opcodes
  16'h0BA9, 16'hF000,
  16'h7101, 16'h7202, 16'h74FF, 16'h847F,                      // R1=1 R2=2 R4=7FFF
  16'h0511, 16'hC001, 16'h7601, 16'h1511, 16'hC001, 16'h7602,  // ccc 000
  16'h1511, 16'hC201, 16'h7603, 16'h0511, 16'hC201, 16'h7604,  // ccc 001
  16'h0511, 16'hC401, 16'h7605, 16'h1512, 16'hC401, 16'h7606,  // ccc 010
  16'h1512, 16'hC601, 16'h7607, 16'h0511, 16'hC601, 16'h7608,  // ccc 011
  16'h1511, 16'hC801, 16'h7609, 16'h1512, 16'hC801, 16'h760A,  // ccc 100
  16'h1512, 16'hCA01, 16'h760B, 16'h0511, 16'hCA01, 16'h760C,  // ccc 101
  16'h0541, 16'hCC01, 16'h760D, 16'h0511, 16'hCC01, 16'h760E,  // ccc 110, overflow first
  16'h0511, 16'hCE02, 16'h760F, 16'h7610, 16'hF000,            // Always, skips two
  16'h7103, 16'h7201, 16'h1112, 16'hC1FE, 16'hCE01, 16'hF000,  // Count down, jump over HLT
  16'h737F, 16'hF000, 16'h7455
};

localparam logic [19:0] expBeats [44] = '{
  20'h10005, 20'h2FFFE, 20'h30003, 20'h4FFFE, 20'h50002, 20'h60001,
  20'h68001, 20'h7F800, 20'h80800, 20'h90002, 20'hA0005, 20'hB0007,
  20'h10001, 20'h20002, 20'h4FFFF, 20'h47FFF,
  20'h50002, 20'h50000, 20'h60002, 20'h50000, 20'h50002, 20'h60004,  // Markers only if not taken
  20'h50002, 20'h5FFFF, 20'h60006, 20'h5FFFF, 20'h50002, 20'h60008,
  20'h50000, 20'h5FFFF, 20'h6000A, 20'h5FFFF, 20'h50002, 20'h6000C,
  20'h58000, 20'h50002, 20'h6000E, 20'h50002,
  20'h10003, 20'h20001, 20'h10002, 20'h10001, 20'h10000, 20'h3007F
};

function automatic string progName(input int idx);
  case (idx)
    0:       return "aluChain";
    1:       return "branchConds";
    default: return "loopAndHalt";
  endcase
endfunction

`endif

/* bench/cpuTb.sv */
`default_nettype none

module cpuTb;

  logic             clk;
  logic             reset;
  cpuPkg::progWrite progWrite;
  cpuPkg::pcWord    pc;
  logic             hlt;
  cpuPkg::wbBus     wbBus;
  logic [19:0]      seenBeats [$];  // {addr, data} of each valid beat

  `include "cpuPrograms.svh"

  localparam int resetCycles  = 10;
  localparam int runTimeout   = 200;
  localparam int settleCycles = 8;   // Watch window after hlt

  cpuTop dut_i (
    .clk       (clk),
    .reset     (reset),
    .progWrite (progWrite),
    .pc        (pc),
    .hlt       (hlt),
    .wbBus     (wbBus)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic failRun(input string why);
    $display("%s", why);
    $display("TEST RESULT: FAIL");
    $fatal(1, "Stopped at first error");
  endtask

  //////////////////////////////////////////////////////////////////////
  // Reset with program load, inputs change on falling edges
  //////////////////////////////////////////////////////////////////////
  task automatic loadAndReset(input int idx);
    int n;
    reset     = 1'b1;
    progWrite = '0;
    n = 0;
    while (n < resetCycles || n < wordCount[idx]) begin  // At least 10 cycles
      @(negedge clk);
      progWrite.addr = cpuPkg::pcWord'(n);
      if (n < wordCount[idx]) begin
        progWrite.en   = 1'b1;
        progWrite.data = progWords[wordStart[idx] + n];
      end else begin
        progWrite.en   = 1'b0;
        progWrite.data = cpuPkg::nopInstr;
      end
      n++;
    end
    @(negedge clk);
    progWrite = '0;
    assert (pc == '0)
      else failRun($sformatf("ERR %s reset pc expected %h actual %h", progName(idx), 16'h0, pc));
    assert (!hlt)
      else failRun($sformatf("ERR %s reset hlt expected 0 actual %b", progName(idx), hlt));
    assert (!wbBus.valid)
      else failRun($sformatf("A wbBus beat showed up during reset in %s", progName(idx)));
    reset = 1'b0;
  endtask

  // Gather beats mid-cycle until hlt rises
  task automatic runToHalt(input int idx);
    int cyc;
    seenBeats.delete();
    cyc = 0;
    while (!hlt && cyc < runTimeout) begin
      @(negedge clk);
      if (wbBus.valid) seenBeats.push_back({wbBus.addr, wbBus.data});
      cyc++;
    end
    assert (hlt)
      else failRun($sformatf("Timed out after %0d cycles waiting for hlt in %s",
                             runTimeout, progName(idx)));
  endtask

  task automatic checkBeats(input int idx);
    logic [19:0] exp;
    assert (seenBeats.size() == beatCount[idx])
      else failRun($sformatf("ERR %s beat count expected %0d actual %0d",
                             progName(idx), beatCount[idx], seenBeats.size()));
    for (int i = 0; i < beatCount[idx]; i++) begin
      exp = expBeats[beatStart[idx] + i];
      assert (seenBeats[i] == exp)
        else failRun($sformatf("ERR %s beat %0d expected R%0d=%h actual R%0d=%h",
                               progName(idx), i, exp[19:16], exp[15:0],
                               seenBeats[i][19:16], seenBeats[i][15:0]));
    end
  endtask

  // Nothing retires and pc sits still after halt
  task automatic checkHaltHolds(input int idx);
    for (int i = 0; i < settleCycles; i++) begin
      @(negedge clk);
      assert (pc == haltPc[idx])
        else failRun($sformatf("ERR %s halted pc expected %h actual %h",
                               progName(idx), haltPc[idx], pc));
      assert (hlt)
        else failRun($sformatf("hlt dropped after the halt in %s", progName(idx)));
      assert (!wbBus.valid)
        else failRun($sformatf("An instruction retired after the halt in %s", progName(idx)));
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Table loop
  //////////////////////////////////////////////////////////////////////
  initial begin
    reset     = 1'b1;
    progWrite = '0;
    for (int p = 0; p < progCount; p++) begin
      loadAndReset(p);
      runToHalt(p);
      checkBeats(p);
      checkHaltHolds(p);
      $display("%s matched %0d beats", progName(p), seenBeats.size());
    end
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

/* compile.f */
+incdir+bench
verilog/cpuPkg.sv
verilog/fetchUnit.sv
verilog/regFile.sv
verilog/decodeStage.sv
verilog/aluUnit.sv
verilog/executeStage.sv
verilog/cpuTop.sv
bench/cpu_assertions.sv
bench/cpuTb.sv

/* run.sh */
#!/usr/bin/env bash
# Build the CPU testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f --top-module cpuTb -o cpuSim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

simOut=$(./obj_dir/cpuSim)
simStatus=$?
echo "$simOut"
if [ $simStatus -ne 0 ]; then
  echo "Simulation exited with status $simStatus"
  exit 1
fi

if echo "$simOut" | grep -qx "TEST RESULT: PASS"; then
  exit 0
fi
exit 1
